/* hw/fm_mmr_pkg.sv */
// Shared register numbers, divider modes, field types and sizes for the FM register interface
package fm_mmr_pkg;

    // Register numbers handled by the interface
    // Channel registers use their base value and carry the channel in bits 1:0
    typedef enum logic [7:0] {
        REG_LFO        = 8'h22,
        REG_TIMER_A_HI = 8'h24,
        REG_TIMER_A_LO = 8'h25,
        REG_TIMER_B    = 8'h26,
        REG_TIMER_CTL  = 8'h27,
        REG_KEYON      = 8'h28,
        REG_PCM        = 8'h2A,
        REG_PCM_EN     = 8'h2B,
        REG_DIV6       = 8'h2D,
        REG_DIV3       = 8'h2E,
        REG_DIV2       = 8'h2F,
        REG_FNUM_LO    = 8'hA0,
        REG_FNUM_LATCH = 8'hA4,
        REG_FB_ALG     = 8'hB0
    } reg_addr_e;

    // Prescaler modes
    // The unlisted code 2'b01 also divides by two
    typedef enum logic [1:0] {
        DIV_2 = 2'b00,
        DIV_6 = 2'b10,
        DIV_3 = 2'b11
    } div_mode_e;

    typedef logic [2:0]  ch_code_t;  // {part, low register bits}
    typedef logic [10:0] fnum_t;
    typedef logic [2:0]  block_t;
    typedef logic [9:0]  timer_a_t;
    typedef logic [7:0]  timer_b_t;
    typedef logic [8:0]  pcm_t;
    typedef logic [3:0]  op_mask_t;

    localparam int BUSY_PULSES  = 32;
    localparam int BUSY_CNT_W   = $clog2(BUSY_PULSES);
    localparam int NUM_CH_SLOTS = 8;  // Slots 3 and 7 unused

    // Prescaler counter and its terminal counts
    localparam int DIV_CNT_W = 3;
    localparam logic [DIV_CNT_W-1:0] DIV6_LAST = 3'd5;
    localparam logic [DIV_CNT_W-1:0] DIV3_LAST = 3'd2;
    localparam logic [DIV_CNT_W-1:0] DIV2_LAST = 3'd1;

endpackage

/* hw/fm_clk_div.sv */
// Prescaler that turns the input clock enable into the FM clock enable at the selected ratio
module fm_clk_div import fm_mmr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      cen,
    input  div_mode_e div_mode,
    output logic      clk_en
);

    logic [DIV_CNT_W-1:0] cnt;
    logic [DIV_CNT_W-1:0] last;
    div_mode_e            prev_mode;

    always_comb begin
        case (div_mode)
            DIV_6:   last = DIV6_LAST;
            DIV_3:   last = DIV3_LAST;
            default: last = DIV2_LAST;  // 00 and 01
        endcase
    end

    // Pulse on the terminal count
    assign clk_en = cen && (cnt == last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt       <= '0;
            prev_mode <= DIV_6;
        end else begin
            prev_mode <= div_mode;
            if (div_mode != prev_mode) begin
                cnt <= '0;  // Restart on a new ratio
            end else if (cen) begin
                cnt <= (cnt >= last) ? '0 : cnt + 1'b1;
            end
        end
    end

endmodule

/* hw/fm_bus_decoder.sv */
// Host write decoder that turns address and data cycles into a register strobe and runs busy
module fm_bus_decoder import fm_mmr_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       write,
    input  logic       clk_en,
    output logic       reg_wr,
    output reg_addr_e  reg_num,
    output logic       reg_part,
    output logic [7:0] reg_data,
    output div_mode_e  div_mode,
    output logic       busy
);

    reg_addr_e             sel_num;   // Register picked by the last address cycle
    logic                  sel_part;
    logic                  old_write;
    logic [BUSY_CNT_W-1:0] busy_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_num   <= reg_addr_e'(8'h00);
            sel_part  <= 1'b0;
            div_mode  <= DIV_6;
            reg_wr    <= 1'b0;
            old_write <= 1'b0;
        end else begin
            old_write <= write;
            reg_wr    <= write && addr[0];
            if (write && !addr[0]) begin
                sel_num  <= reg_addr_e'(din);
                sel_part <= addr[1];
                // Selecting the register is enough and the data byte is ignored
                case (din)
                    REG_DIV6: div_mode <= div_mode_e'(div_mode | 2'b10);
                    REG_DIV3: div_mode <= div_mode_e'(div_mode | 2'b01);
                    REG_DIV2: div_mode <= DIV_2;
                    default: ;
                endcase
            end
        end
    end

    // Strobe payload
    always_ff @(posedge clk) begin
        if (write && addr[0]) begin
            reg_num  <= sel_num;
            reg_part <= sel_part;
            reg_data <= din;
        end
    end

    // Busy lasts a fixed number of FM clock enables after each data write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (write && !old_write && addr[0]) begin
            busy     <= 1'b1;
            busy_cnt <= '0;  // Restarts on every new write
        end else if (clk_en && busy) begin
            if (busy_cnt == BUSY_CNT_W'(BUSY_PULSES - 1)) begin
                busy <= 1'b0;
            end
            busy_cnt <= busy_cnt + 1'b1;
        end
    end

endmodule

/* hw/fm_global_regs.sv */
// Global register bank holding timers, LFO and PCM settings written through the decoder strobe
module fm_global_regs import fm_mmr_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       clk_en,
    input  logic       reg_wr,
    input  reg_addr_e  reg_num,
    input  logic       reg_part,
    input  logic [7:0] reg_data,
    output timer_a_t   timer_a,
    output timer_b_t   timer_b,
    output logic       load_a,
    output logic       load_b,
    output logic       irq_en_a,
    output logic       irq_en_b,
    output logic       clr_flag_a,
    output logic       clr_flag_b,
    output logic       lfo_en,
    output logic [2:0] lfo_freq,
    output pcm_t       pcm,
    output logic       pcm_en,
    output logic       pcm_wr
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timer_a    <= '0;
            timer_b    <= '0;
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            irq_en_a   <= 1'b0;
            irq_en_b   <= 1'b0;
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            lfo_en     <= 1'b0;
            lfo_freq   <= '0;
            pcm        <= '0;
            pcm_en     <= 1'b0;
            pcm_wr     <= 1'b0;
        end else if (reg_wr) begin
            if (!reg_part) begin  // Upper bank has no globals
                case (reg_num)
                    REG_TIMER_A_HI: timer_a[9:2] <= reg_data;
                    REG_TIMER_A_LO: timer_a[1:0] <= reg_data[1:0];
                    REG_TIMER_B:    timer_b      <= reg_data;
                    REG_TIMER_CTL: begin
                        {clr_flag_b, clr_flag_a, irq_en_b, irq_en_a,
                         load_b, load_a} <= reg_data[5:0];
                    end
                    REG_LFO:    {lfo_en, lfo_freq} <= reg_data[3:0];
                    REG_PCM: begin
                        pcm    <= {~reg_data[7], reg_data[6:0], 1'b1};  // Offset binary
                        pcm_wr <= 1'b1;
                    end
                    REG_PCM_EN: pcm_en <= reg_data[7];
                    default: ;
                endcase
            end
        end else if (clk_en) begin
            // One-shot bits end on the next idle FM clock enable
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            pcm_wr     <= 1'b0;
        end
    end

endmodule

/* hw/fm_chan_regs.sv */
// Per-channel register file with the shared frequency latch and a channel read port
module fm_chan_regs import fm_mmr_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       reg_wr,
    input  reg_addr_e  reg_num,
    input  logic       reg_part,
    input  logic [7:0] reg_data,
    input  ch_code_t   ch_sel,
    output fnum_t      fnum,
    output block_t     block,
    output logic [2:0] fb,
    output logic [2:0] alg,
    output op_mask_t   keyon
);

    fnum_t      fnum_mem  [NUM_CH_SLOTS];
    block_t     block_mem [NUM_CH_SLOTS];
    logic [2:0] fb_mem    [NUM_CH_SLOTS];
    logic [2:0] alg_mem   [NUM_CH_SLOTS];
    op_mask_t   keyon_mem [NUM_CH_SLOTS];

    logic [5:0] fnum_latch;  // One latch for every channel
    logic [7:0] num_bits;
    logic [7:0] num_base;
    ch_code_t   wr_ch;
    logic       wr_ch_ok;
    logic       rd_ok;

    assign num_bits = reg_num;
    assign num_base = {num_bits[7:2], 2'b00};
    assign wr_ch    = {reg_part, num_bits[1:0]};
    assign wr_ch_ok = num_bits[1:0] != 2'b11;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fnum_latch <= '0;
            for (int i = 0; i < NUM_CH_SLOTS; i++) begin
                fnum_mem[i]  <= '0;
                block_mem[i] <= '0;
                fb_mem[i]    <= '0;
                alg_mem[i]   <= '0;
                keyon_mem[i] <= '0;
            end
        end else if (reg_wr) begin
            if (wr_ch_ok && num_base == REG_FNUM_LATCH) begin
                fnum_latch <= reg_data[5:0];
            end
            // Low byte write commits the latched high bits too
            if (wr_ch_ok && num_base == REG_FNUM_LO) begin
                block_mem[wr_ch] <= fnum_latch[5:3];
                fnum_mem[wr_ch]  <= {fnum_latch[2:0], reg_data};
            end
            if (wr_ch_ok && num_base == REG_FB_ALG) begin
                fb_mem[wr_ch]  <= reg_data[5:3];
                alg_mem[wr_ch] <= reg_data[2:0];
            end
            // Key-on names its channel in the data byte
            if (!reg_part && reg_num == REG_KEYON && reg_data[1:0] != 2'b11) begin
                keyon_mem[reg_data[2:0]] <= reg_data[7:4];
            end
        end
    end

    assign rd_ok = ch_sel[1:0] != 2'b11;  // Low bits 3 read as zero
    assign fnum  = rd_ok ? fnum_mem[ch_sel]  : '0;
    assign block = rd_ok ? block_mem[ch_sel] : '0;
    assign fb    = rd_ok ? fb_mem[ch_sel]    : '0;
    assign alg   = rd_ok ? alg_mem[ch_sel]   : '0;
    assign keyon = rd_ok ? keyon_mem[ch_sel] : '0;

endmodule

/* hw/fm_mmr_top.sv */
// Top level of the FM host register interface tying decoder, prescaler and both banks together
module fm_mmr_top import fm_mmr_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [7:0] din,
    input  logic [1:0] addr,
    input  logic       write,
    input  ch_code_t   ch_sel,
    output logic       busy,
    output logic       clk_en,
    output timer_a_t   timer_a,
    output timer_b_t   timer_b,
    output logic       load_a,
    output logic       load_b,
    output logic       irq_en_a,
    output logic       irq_en_b,
    output logic       clr_flag_a,
    output logic       clr_flag_b,
    output logic       lfo_en,
    output logic [2:0] lfo_freq,
    output pcm_t       pcm,
    output logic       pcm_en,
    output logic       pcm_wr,
    output fnum_t      fnum,
    output block_t     block,
    output logic [2:0] fb,
    output logic [2:0] alg,
    output op_mask_t   keyon
);

    div_mode_e  div_mode;
    logic       reg_wr;
    reg_addr_e  reg_num;
    logic       reg_part;
    logic [7:0] reg_data;

    fm_clk_div i_fm_clk_div (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .div_mode (div_mode),
        .clk_en   (clk_en)
    );

    fm_bus_decoder i_fm_bus_decoder (
        .clk      (clk),
        .rst      (rst),
        .din      (din),
        .addr     (addr),
        .write    (write),
        .clk_en   (clk_en),
        .reg_wr   (reg_wr),
        .reg_num  (reg_num),
        .reg_part (reg_part),
        .reg_data (reg_data),
        .div_mode (div_mode),
        .busy     (busy)
    );

    // Both banks see the same strobe
    fm_global_regs i_fm_global_regs (
        .clk        (clk),
        .rst        (rst),
        .clk_en     (clk_en),
        .reg_wr     (reg_wr),
        .reg_num    (reg_num),
        .reg_part   (reg_part),
        .reg_data   (reg_data),
        .timer_a    (timer_a),
        .timer_b    (timer_b),
        .load_a     (load_a),
        .load_b     (load_b),
        .irq_en_a   (irq_en_a),
        .irq_en_b   (irq_en_b),
        .clr_flag_a (clr_flag_a),
        .clr_flag_b (clr_flag_b),
        .lfo_en     (lfo_en),
        .lfo_freq   (lfo_freq),
        .pcm        (pcm),
        .pcm_en     (pcm_en),
        .pcm_wr     (pcm_wr)
    );

    fm_chan_regs i_fm_chan_regs (
        .clk      (clk),
        .rst      (rst),
        .reg_wr   (reg_wr),
        .reg_num  (reg_num),
        .reg_part (reg_part),
        .reg_data (reg_data),
        .ch_sel   (ch_sel),
        .fnum     (fnum),
        .block    (block),
        .fb       (fb),
        .alg      (alg),
        .keyon    (keyon)
    );

endmodule

/* include/tb_fm_mmr_tasks.svh */
// Bus access, compare and directed test tasks; included into the testbench module body

function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

task automatic note_result(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("ERR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    end
endtask

task automatic cmp_fnum(input string name, input fnum_t exp, input fnum_t act);
    note_result(name, exp, act);
endtask

task automatic cmp_block(input string name, input block_t exp, input block_t act);
    note_result(name, exp, act);
endtask

task automatic cmp_u8(input string name, input logic [7:0] exp, input logic [7:0] act);
    note_result(name, exp, act);
endtask

task automatic cmp_timer_a(input string name, input timer_a_t exp, input timer_a_t act);
    note_result(name, exp, act);
endtask

task automatic cmp_pcm(input string name, input pcm_t exp, input pcm_t act);
    note_result(name, exp, act);
endtask

task automatic cmp_mask(input string name, input op_mask_t exp, input op_mask_t act);
    note_result(name, exp, act);
endtask

task automatic cmp_bit(input string name, input logic exp, input logic act);
    note_result(name, exp, act);
endtask

// One host cycle with write high starting on a falling edge
task automatic write_cycle(input logic [1:0] a, input logic [7:0] d);
    addr  = a;
    din   = d;
    write = 1'b1;
    @(negedge clk);
    write = 1'b0;
endtask

// Address cycle, gap, data cycle; returns one cycle after the data is sampled
task automatic start_write(input logic part, input logic [7:0] num, input logic [7:0] data);
    write_cycle({part, 1'b0}, num);
    @(negedge clk);  // Gap gives busy a rising edge of write
    write_cycle({part, 1'b1}, data);
endtask

task automatic bus_write(input logic part, input logic [7:0] num, input logic [7:0] data);
    start_write(part, num, data);
    repeat (3) @(negedge clk);
endtask

function automatic logic [7:0] chan_reg(input reg_addr_e base, input ch_code_t ch);
    return 8'(base) | {6'd0, ch[1:0]};
endfunction

function automatic logic [7:0] timer_ctl_bits();
    return {2'b00, clr_flag_b, clr_flag_a, irq_en_b, irq_en_a, load_b, load_a};
endfunction

// Cycles between two clk_en pulses
task automatic measure_period(output int cycles);
    cycles = 0;
    while (clk_en !== 1'b1) @(negedge clk);
    do begin
        @(negedge clk);
        cycles++;
    end while (clk_en !== 1'b1);
endtask

task automatic wait_clk_en();
    while (clk_en !== 1'b1) @(negedge clk);
    @(negedge clk);  // Past the edge that uses the pulse
endtask

task automatic test_reset_state();
    int period;
    cmp_u8("reset pulses",
           8'h00, {2'b00, busy, load_a, load_b, clr_flag_a, clr_flag_b, pcm_wr});
    cmp_timer_a("reset timer_a", '0, timer_a);
    measure_period(period);
    cmp_u8("reset clk_en period", 8'd6, 8'(period));
endtask

task automatic test_prescaler();
    int period;
    write_cycle(2'b00, REG_DIV2);
    repeat (3) @(negedge clk);
    measure_period(period);
    cmp_u8("prescaler div2 period", 8'd2, 8'(period));
    write_cycle(2'b00, REG_DIV6);
    @(negedge clk);
    write_cycle(2'b00, REG_DIV3);
    repeat (3) @(negedge clk);
    measure_period(period);
    cmp_u8("prescaler div3 period", 8'd3, 8'(period));
    // 2D alone keeps divide by 3, so go through 2F first
    write_cycle(2'b00, REG_DIV2);
    @(negedge clk);
    write_cycle(2'b00, REG_DIV6);
    repeat (3) @(negedge clk);
    measure_period(period);
    cmp_u8("prescaler div6 period", 8'd6, 8'(period));
endtask

task automatic test_global_regs();
    logic [7:0] d_hi;
    logic [7:0] d_lo;
    logic [7:0] d_b;
    logic [7:0] d_lfo;
    logic [7:0] d_en;
    logic [7:0] d_pcm;
    d_hi  = 8'(next_random());
    d_lo  = 8'(next_random());
    d_b   = 8'(next_random());
    d_lfo = 8'(next_random()) | 8'h08;  // Enable bits set so they move off reset
    d_en  = 8'(next_random()) | 8'h80;
    d_pcm = 8'(next_random());
    bus_write(1'b0, REG_TIMER_A_HI, d_hi);
    bus_write(1'b0, REG_TIMER_A_LO, d_lo);
    bus_write(1'b0, REG_TIMER_B, d_b);
    bus_write(1'b0, REG_LFO, d_lfo);
    bus_write(1'b0, REG_PCM_EN, d_en);
    exp_timer_a = {d_hi, d_lo[1:0]};
    cmp_timer_a("global timer_a", exp_timer_a, timer_a);
    cmp_u8("global timer_b", d_b, timer_b);
    cmp_bit("global lfo_en", d_lfo[3], lfo_en);
    cmp_u8("global lfo_freq", {5'd0, d_lfo[2:0]}, {5'd0, lfo_freq});
    cmp_bit("global pcm_en", d_en[7], pcm_en);
    start_write(1'b0, REG_PCM, d_pcm);
    @(negedge clk);
    cmp_bit("global pcm_wr high", 1'b1, pcm_wr);
    cmp_pcm("global pcm", {~d_pcm[7], d_pcm[6:0], 1'b1}, pcm);
    wait_clk_en();
    cmp_bit("global pcm_wr low", 1'b0, pcm_wr);
endtask

task automatic test_timer_ctl();
    start_write(1'b0, REG_TIMER_CTL, 8'h3F);
    @(negedge clk);
    cmp_u8("timer ctl set", 8'h3F, timer_ctl_bits());
    wait_clk_en();
    cmp_u8("timer ctl flags cleared", 8'h0F, timer_ctl_bits());
    // Upper part has no timer registers
    bus_write(1'b1, REG_TIMER_A_HI, ~exp_timer_a[9:2]);
    cmp_timer_a("timer part 1 write", exp_timer_a, timer_a);
endtask

task automatic test_channels();
    fnum_t      exp_fnum  [NUM_CH_SLOTS];
    block_t     exp_block [NUM_CH_SLOTS];
    logic [5:0] exp_fbalg [NUM_CH_SLOTS];
    ch_code_t   ch;
    logic [7:0] latch;
    logic [7:0] lo;
    logic [7:0] fbalg;
    for (int i = 0; i < NUM_CH_SLOTS; i++) begin
        exp_fnum[i]  = '0;
        exp_block[i] = '0;
        exp_fbalg[i] = '0;
    end
    for (int i = 0; i < NUM_CH_SLOTS; i++) begin
        ch = ch_code_t'(i);
        if (ch[1:0] != 2'b11) begin
            latch = 8'(next_random());
            lo    = 8'(next_random());
            fbalg = 8'(next_random());
            bus_write(ch[2], chan_reg(REG_FNUM_LATCH, ch), latch);
            bus_write(ch[2], chan_reg(REG_FNUM_LO, ch), lo);
            bus_write(ch[2], chan_reg(REG_FB_ALG, ch), fbalg);
            exp_fnum[i]  = {latch[2:0], lo};
            exp_block[i] = latch[5:3];
            exp_fbalg[i] = fbalg[5:0];
        end
    end
    // Read back after all writes so crosstalk shows up
    for (int i = 0; i < NUM_CH_SLOTS; i++) begin
        ch_sel = ch_code_t'(i);
        @(negedge clk);
        cmp_fnum($sformatf("chan %0d fnum", i), exp_fnum[i], fnum);
        cmp_block($sformatf("chan %0d block", i), exp_block[i], block);
        cmp_u8($sformatf("chan %0d fb/alg", i), {2'b00, exp_fbalg[i]}, {2'b00, fb, alg});
    end
endtask

task automatic test_keyon_busy();
    op_mask_t exp_keyon [NUM_CH_SLOTS];
    ch_code_t ch;
    op_mask_t mask;
    int       busy_cycles;
    for (int i = 0; i < NUM_CH_SLOTS; i++) begin
        exp_keyon[i] = '0;
    end
    while (busy === 1'b1) @(negedge clk);  // Let earlier writes finish
    ch = ch_code_t'(next_random());
    if (ch[1:0] == 2'b11) begin
        ch[1:0] = 2'b00;
    end
    mask = op_mask_t'(next_random()) | 4'b0001;
    start_write(1'b0, REG_KEYON, {mask, 1'b0, ch});
    exp_keyon[ch] = mask;
    @(negedge clk);
    cmp_bit("keyon busy high", 1'b1, busy);
    busy_cycles = 1;
    while (busy === 1'b1 && busy_cycles <= BUSY_PULSES * 6 + 6) begin
        @(negedge clk);
        busy_cycles++;
    end
    if (busy_cycles < (BUSY_PULSES - 1) * 6 || busy_cycles > BUSY_PULSES * 6 + 6) begin
        error_count++;
        $display("keyon: busy stayed high for %0d cycles, outside the expected window",
                 busy_cycles);
    end
    bus_write(1'b0, REG_KEYON, 8'hF3);  // Low bits 3 name no channel
    for (int i = 0; i < NUM_CH_SLOTS; i++) begin
        ch_sel = ch_code_t'(i);
        @(negedge clk);
        cmp_mask($sformatf("keyon chan %0d", i), exp_keyon[i], keyon);
    end
endtask

/* tb/tb_fm_mmr.sv */
// Testbench top for the FM register interface; runs the directed tests and prints a summary
module tb_fm_mmr import fm_mmr_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 6000;  // Six tests at about 1000 cycles each

    logic       clk;
    logic       rst;
    logic       cen;
    logic       write;
    logic [7:0] din;
    logic [1:0] addr;
    ch_code_t   ch_sel;

    logic       busy;
    logic       clk_en;
    timer_a_t   timer_a;
    timer_b_t   timer_b;
    logic       load_a;
    logic       load_b;
    logic       irq_en_a;
    logic       irq_en_b;
    logic       clr_flag_a;
    logic       clr_flag_b;
    logic       lfo_en;
    logic [2:0] lfo_freq;
    pcm_t       pcm;
    logic       pcm_en;
    logic       pcm_wr;
    fnum_t      fnum;
    block_t     block;
    logic [2:0] fb;
    logic [2:0] alg;
    op_mask_t   keyon;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state   = 32'h399a;
    timer_a_t    exp_timer_a;  // Last timer A value written on part 0

    fm_mmr_top i_fm_mmr_top (.*);

    always #50 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    `include "tb_fm_mmr_tasks.svh"

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        cen         = 1'b1;  // Full rate input enable
        write       = 1'b0;
        din         = '0;
        addr        = '0;
        ch_sel      = '0;
        exp_timer_a = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        test_prescaler();
        test_global_regs();
        test_timer_ctl();
        test_channels();
        test_keyon_busy();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
hw/fm_mmr_pkg.sv
hw/fm_clk_div.sv
hw/fm_bus_decoder.sv
hw/fm_global_regs.sv
hw/fm_chan_regs.sv
hw/fm_mmr_top.sv
tb/tb_fm_mmr.sv

/* Bender.yml */
package:
  name: fm_mmr

sources:
  - files:
      - hw/fm_mmr_pkg.sv
      - hw/fm_clk_div.sv
      - hw/fm_bus_decoder.sv
      - hw/fm_global_regs.sv
      - hw/fm_chan_regs.sv
      - hw/fm_mmr_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_fm_mmr.sv
